// ==== filelist.f ====
+incdir+rtl
rtl/i2c_reg_pkg.sv
rtl/i2c_bus_pkg.sv
rtl/i2c_regfile.sv
rtl/i2c_scl_gen.sv
rtl/i2c_byte_engine.sv
rtl/i2c_master_top.sv
testbench/i2c_slave_model.sv
testbench/tb_i2c_master.sv

// ==== testbench/tb_i2c_master.sv ====
`include "i2c_settings.svh"

module tb_i2c_master;
	timeunit 1ns;
	timeprecision 100ps;

	logic        clk_i2c;
	logic        reset_i;
	logic        write;
	logic [3:0]  be;
	logic [4:0]  addr;
	logic [31:0] wdata;
	logic [31:0] rdata;
	logic        scl_oe_m;
	logic        sda_oe_m;
	logic        sda_oe_s;
	wire         scl_line;
	wire         sda_line;
	logic [31:0] slv_data;
	int          slv_count;
	int          slv_starts;
	int          slv_errors;
	int          scl_rises;
	int          checks;
	int          fails;
	int          fails_before;
	logic [2:0]  m_nby;
	logic [6:0]  m_adr;
	logic [31:0] m_tdr;
	logic [31:0] m_rdr;
	logic [4:0]  m_cfg;

	// Wired-AND lines with 1 ns of wire delay.
	assign #1 scl_line = !scl_oe_m;
	assign #1 sda_line = !(sda_oe_m || sda_oe_s);

	always #5 clk_i2c = !clk_i2c;

	// Counts SCL rising edges on the bus.
	always @(posedge scl_line) begin
		if (!reset_i) begin
			scl_rises++;
		end
	end

	i2c_master_top u_i2c_master_top (
		.clk_i2c  (clk_i2c),
		.reset_i  (reset_i),
		.write_i  (write),
		.be_i     (be),
		.addr_i   (addr),
		.wdata_i  (wdata),
		.rdata_o  (rdata),
		.sda_i    (sda_line),
		.scl_oe_o (scl_oe_m),
		.sda_oe_o (sda_oe_m)
	);

	i2c_slave_model u_slave (
		.reset_i       (reset_i),
		.scl_i         (scl_line),
		.sda_i         (sda_line),
		.sda_oe_o      (sda_oe_s),
		.wr_data_o     (slv_data),
		.wr_count_o    (slv_count),
		.start_count_o (slv_starts),
		.error_count_o (slv_errors)
	);

	function automatic void model_write(input logic [4:0] a, input logic [3:0] b,
		input logic [31:0] d);
		case (a)
			`I2C_OFS_NBY: if (b[0]) m_nby = d[2:0];
			`I2C_OFS_ADR: if (b[0]) m_adr = d[6:0];
			`I2C_OFS_TDR: begin
				for (int i = 0; i < 4; i++) begin
					if (b[i]) m_tdr[8*i +: 8] = d[8*i +: 8];
				end
			end
			`I2C_OFS_CFG: begin
				if (b[0]) m_cfg[1] = d[1];
				// Start clears done and nack.
				if (b[0] && d[0]) m_cfg[4:3] = 2'b00;
			end
			default: ;
		endcase
	endfunction

	function automatic logic [31:0] model_read(input logic [4:0] a, input logic [3:0] b);
		logic [31:0] w;
		logic [31:0] r;
		case (a)
			`I2C_OFS_NBY: w = {29'h0, m_nby};
			`I2C_OFS_ADR: w = {25'h0, m_adr};
			`I2C_OFS_RDR: w = m_rdr;
			`I2C_OFS_TDR: w = m_tdr;
			default: w = {27'h0, m_cfg};
		endcase
		for (int i = 0; i < 4; i++) begin
			r[8*i +: 8] = b[i] ? w[8*i +: 8] : 8'h00;
		end
		return r;
	endfunction

	function automatic logic [31:0] low_bytes(input logic [31:0] d, input int n);
		logic [31:0] r;
		r = '0;
		for (int k = 0; k < n; k++) begin
			r[8*k +: 8] = d[8*k +: 8];
		end
		return r;
	endfunction

	task automatic host_write(input logic [4:0] a, input logic [3:0] b, input logic [31:0] d);
		@(posedge clk_i2c);
		#1;
		write = 1'b1;
		be = b;
		addr = a;
		wdata = d;
		@(posedge clk_i2c);
		#1;
		write = 1'b0;
		be = 4'h0;
		model_write(a, b, d);
	endtask

	task automatic host_read(input logic [4:0] a, input logic [3:0] b, output logic [31:0] d);
		@(posedge clk_i2c);
		#1;
		write = 1'b0;
		addr = a;
		be = b;
		#2;
		d = rdata;
	endtask

	task automatic expect_word(input string name, input logic [31:0] got,
		input logic [31:0] exp);
		checks++;
		if (got !== exp) begin
			fails++;
			$display("FAIL %s: got 0x%08h, expected 0x%08h", name, got, exp);
		end
	endtask

	task automatic check_reg(input logic [4:0] a, input logic [3:0] b);
		logic [31:0] v;
		host_read(a, b, v);
		expect_word("rdata_o", v, model_read(a, b));
	endtask

	task automatic stop_on_timeout(input string what);
		$display("Timeout: %s", what);
		$display("CHECKS FAILED");
		$finish;
	endtask

	// Polls CFG until the given bit is set.
	task automatic wait_cfg_bit(input int idx, input string what);
		logic [31:0] v;
		int n;
		v = '0;
		n = 0;
		while (!v[idx]) begin
			if (n > 60 * 4 * `I2C_QUARTER_DIV) begin
				stop_on_timeout(what);
			end else begin
				host_read(`I2C_OFS_CFG, 4'hF, v);
				n++;
			end
		end
	endtask

	task automatic report_test(input string name);
		$display("Test %s: %s", name, (fails == fails_before) ? "pass" : "fail");
		fails_before = fails;
	endtask

	initial begin
		logic [31:0] d;
		logic [31:0] exp;
		logic [4:0]  a;
		logic [6:0]  t;
		int          n;
		int          starts;
		d = $urandom(42676);
		clk_i2c = 1'b0;
		reset_i = 1'b1;
		write = 1'b0;
		be = 4'h0;
		addr = '0;
		wdata = '0;
		checks = 0;
		fails = 0;
		fails_before = 0;
		scl_rises = 0;
		m_nby = '0;
		m_adr = '0;
		m_tdr = '0;
		m_rdr = '0;
		m_cfg = '0;
		repeat (2) @(posedge clk_i2c);
		#1;
		reset_i = 1'b0;

		for (int r = 0; r < 5; r++) begin
			check_reg(5'(4 * r), 4'hF);
		end
		expect_word("scl_oe_o", {31'h0, scl_oe_m}, 32'h0);
		expect_word("sda_oe_o", {31'h0, sda_oe_m}, 32'h0);
		report_test("reset values");

		for (int i = 0; i < 12; i++) begin
			case ($urandom_range(2))
				0: a = `I2C_OFS_NBY;
				1: a = `I2C_OFS_ADR;
				default: a = `I2C_OFS_TDR;
			endcase
			host_write(a, 4'($urandom), $urandom);
			check_reg(a, 4'($urandom));
		end
		report_test("byte enable writes");

		host_write(`I2C_OFS_ADR, 4'h1, 32'h5A);
		for (int i = 0; i < 5; i++) begin
			n = $urandom_range(4, 1);
			d = $urandom;
			host_write(`I2C_OFS_NBY, 4'h1, 32'(n));
			host_write(`I2C_OFS_TDR, 4'hF, d);
			host_write(`I2C_OFS_CFG, 4'h1, 32'h1);
			wait_cfg_bit(4, "done bit after a write transfer");
			m_cfg[4:3] = 2'b10;
			m_rdr = '0;
			expect_word("slv_count", 32'(slv_count), 32'(n));
			expect_word("slv_data", slv_data, low_bytes(d, n));
			check_reg(`I2C_OFS_CFG, 4'hF);
		end
		report_test("write transfers");

		for (int i = 0; i < 5; i++) begin
			n = $urandom_range(4, 1);
			host_write(`I2C_OFS_NBY, 4'h1, 32'(n));
			host_write(`I2C_OFS_CFG, 4'h1, 32'h3);
			wait_cfg_bit(4, "done bit after a read transfer");
			exp = '0;
			for (int k = 0; k < n; k++) begin
				exp[8*k +: 8] = 8'hA0 + 8'(k);
			end
			m_cfg[4:3] = 2'b10;
			m_rdr = exp;
			check_reg(`I2C_OFS_RDR, 4'hF);
			check_reg(`I2C_OFS_CFG, 4'hF);
		end
		report_test("read transfers");

		t = 7'h5A ^ 7'($urandom_range(127, 1));
		host_write(`I2C_OFS_ADR, 4'h1, 32'(t));
		n = scl_rises;
		host_write(`I2C_OFS_CFG, 4'h1, {30'h0, 1'($urandom), 1'b1});
		wait_cfg_bit(4, "done bit after an address NACK");
		m_cfg[4:3] = 2'b11;
		m_rdr = '0;
		check_reg(`I2C_OFS_CFG, 4'hF);
		check_reg(`I2C_OFS_RDR, 4'hF);
		expect_word("slv_count", 32'(slv_count), 32'h0);
		// Eight address bits, the ACK slot and the STOP.
		expect_word("scl_line rising edges", 32'(scl_rises - n), 32'd10);
		report_test("address NACK");

		host_write(`I2C_OFS_ADR, 4'h1, 32'h5A);
		n = $urandom_range(4, 1);
		d = $urandom;
		host_write(`I2C_OFS_NBY, 4'h1, 32'(n));
		host_write(`I2C_OFS_TDR, 4'hF, d);
		starts = slv_starts;
		host_write(`I2C_OFS_CFG, 4'h1, 32'h1);
		wait_cfg_bit(2, "busy bit after start");
		host_write(`I2C_OFS_TDR, 4'hF, ~d);
		host_write(`I2C_OFS_CFG, 4'h1, 32'h1);
		wait_cfg_bit(4, "done bit after a start during busy");
		// Room for a second transfer to show up if one were accepted.
		repeat (16 * `I2C_QUARTER_DIV) @(posedge clk_i2c);
		m_cfg[4:3] = 2'b10;
		check_reg(`I2C_OFS_CFG, 4'hF);
		check_reg(`I2C_OFS_TDR, 4'hF);
		expect_word("slv_starts", 32'(slv_starts - starts), 32'h1);
		expect_word("slv_data", slv_data, low_bytes(d, n));
		expect_word("slv_errors", 32'(slv_errors), 32'h0);
		report_test("start while busy");

		$display("Checks: %0d, failures: %0d", checks, fails);
		if (fails == 0) begin
			$display("ALL CHECKS PASSED");
		end else begin
			$display("CHECKS FAILED");
		end
		$finish;
	end

endmodule

// ==== testbench/i2c_slave_model.sv ====
module i2c_slave_model (
	input  logic        reset_i,
	input  logic        scl_i,
	input  logic        sda_i,
	output logic        sda_oe_o,
	output logic [31:0] wr_data_o,
	output int          wr_count_o,
	output int          start_count_o,
	output int          error_count_o
);
	timeunit 1ns;
	timeprecision 100ps;

	logic       active;
	logic       first;
	logic       selected;
	logic       reading;
	logic       sending;
	logic [7:0] shift;
	logic [7:0] rd_byte;
	int         bit_cnt;
	int         rd_idx;

	initial begin
		active = 1'b0;
		sending = 1'b0;
		sda_oe_o = 1'b0;
		wr_data_o = '0;
		wr_count_o = 0;
		start_count_o = 0;
		error_count_o = 0;
	end

	// START, SDA falls with SCL high.
	always @(negedge sda_i) begin
		if (!reset_i && scl_i === 1'b1) begin
			if (active) begin
				error_count_o++;
				$display("Slave error: SDA fell while SCL was high in a transfer");
			end
			active = 1'b1;
			first = 1'b1;
			sending = 1'b0;
			bit_cnt = 0;
			wr_count_o = 0;
			wr_data_o = '0;
			start_count_o++;
		end
	end

	// STOP follows one SCL rise with SDA low.
	always @(posedge sda_i) begin
		if (!reset_i && scl_i === 1'b1) begin
			if (!active || bit_cnt != 1) begin
				error_count_o++;
				$display("Slave error: SDA rose while SCL was high outside a STOP");
			end
			active = 1'b0;
			sda_oe_o = 1'b0;
		end
	end

	always @(posedge scl_i) begin
		if (!reset_i && active) begin
			if (bit_cnt < 8) begin
				shift = {shift[6:0], sda_i};
			end else if (sending && sda_i) begin
				// Master NACK ends the read.
				sending = 1'b0;
			end
			bit_cnt++;
			if (bit_cnt == 8 && first) begin
				selected = (shift[7:1] == 7'h5A);
				reading = shift[0];
			end else if (bit_cnt == 8 && selected && !reading && wr_count_o < 4) begin
				wr_data_o[8*wr_count_o +: 8] = shift;
				wr_count_o++;
			end
		end
	end

	// SDA only changes while SCL is low.
	always @(negedge scl_i) begin
		if (!reset_i && active) begin
			if (bit_cnt == 9) begin
				bit_cnt = 0;
				if (first && selected && reading) begin
					sending = 1'b1;
					rd_idx = 0;
				end else if (sending) begin
					rd_idx++;
				end
				first = 1'b0;
			end
			rd_byte = 8'hA0 + 8'(rd_idx);
			if (bit_cnt == 8) begin
				sda_oe_o = selected && (first || !reading);
			end else begin
				sda_oe_o = sending && !rd_byte[7 - bit_cnt];
			end
		end
	end

endmodule

// ==== rtl/i2c_master_top.sv ====
module i2c_master_top
	import i2c_reg_pkg::*;
	import i2c_bus_pkg::*;
(
	input  logic        clk_i2c,
	input  logic        reset_i,
	input  logic        write_i,
	input  logic [3:0]  be_i,
	input  logic [4:0]  addr_i,
	input  logic [31:0] wdata_i,
	output logic [31:0] rdata_o,
	input  logic        sda_i,
	output logic        scl_oe_o,
	output logic        sda_oe_o
);

	host_req_t   req;
	job_t        job;
	logic        start;
	scl_phase_t  phase;
	eng_status_t status;

	assign req.write = write_i;
	assign req.be = be_i;
	assign req.addr = addr_i;
	assign req.wdata = wdata_i;

	i2c_regfile u_regfile (
		.clk_i2c  (clk_i2c),
		.reset_i  (reset_i),
		.req_i    (req),
		.rdata_o  (rdata_o),
		.status_i (status),
		.job_o    (job),
		.start_o  (start)
	);

	// Divider runs only during a transfer.
	i2c_scl_gen u_scl_gen (
		.clk_i2c (clk_i2c),
		.reset_i (reset_i),
		.run_i   (status.busy),
		.phase_o (phase)
	);

	i2c_byte_engine u_engine (
		.clk_i2c  (clk_i2c),
		.reset_i  (reset_i),
		.job_i    (job),
		.start_i  (start),
		.phase_i  (phase),
		.sda_i    (sda_i),
		.scl_oe_o (scl_oe_o),
		.sda_oe_o (sda_oe_o),
		.status_o (status)
	);

endmodule

// ==== rtl/i2c_byte_engine.sv ====
module i2c_byte_engine
	import i2c_reg_pkg::*;
	import i2c_bus_pkg::*;
(
	input  logic        clk_i2c,
	input  logic        reset_i,
	input  job_t        job_i,
	input  logic        start_i,
	input  scl_phase_t  phase_i,
	input  logic        sda_i,
	output logic        scl_oe_o,
	output logic        sda_oe_o,
	output eng_status_t status_o
);

	typedef enum logic [2:0] {
		IDLE,
		START,
		ADDR,
		ACK0,
		DATA,
		ACK1,
		STOP
	} state_e;

	state_e      state_q;
	logic [2:0]  bit_q;
	logic [1:0]  byte_q;
	logic [31:0] rx_q;
	logic        nack_q;
	logic [7:0]  addr_byte;
	logic        last_byte;
	logic        sample;
	logic        bit_end;
	logic        scl_low;
	logic        tx_bit;

	assign addr_byte = {job_i.target, job_i.read};
	assign last_byte = (byte_q == job_i.nbytes);
	assign tx_bit = job_i.tdata[{byte_q, bit_q}];

	// Sample at the end of SCL high, advance at the end of the bit.
	assign sample = phase_i.tick && (phase_i.phase == 2'd2);
	assign bit_end = phase_i.tick && (phase_i.phase == 2'd3);
	assign scl_low = (phase_i.phase == 2'd0) || (phase_i.phase == 2'd3);

	always_ff @(posedge clk_i2c) begin
		if (reset_i) begin
			state_q <= IDLE;
			bit_q <= '0;
			byte_q <= '0;
			nack_q <= 1'b0;
		end else begin
			case (state_q)
				IDLE: begin
					if (start_i) begin
						state_q <= START;
						bit_q <= 3'd7;
						byte_q <= '0;
						nack_q <= 1'b0;
					end
				end
				START: begin
					if (bit_end) begin
						state_q <= ADDR;
					end
				end
				ADDR: begin
					if (bit_end) begin
						bit_q <= bit_q - 3'd1;
						if (bit_q == 3'd0) begin
							state_q <= ACK0;
						end
					end
				end
				ACK0: begin
					if (sample && sda_i) begin
						nack_q <= 1'b1;
					end
					// Address NACK skips the data.
					if (bit_end) begin
						state_q <= nack_q ? STOP : DATA;
					end
				end
				DATA: begin
					if (bit_end) begin
						bit_q <= bit_q - 3'd1;
						if (bit_q == 3'd0) begin
							state_q <= ACK1;
						end
					end
				end
				ACK1: begin
					if (sample && sda_i && !job_i.read) begin
						nack_q <= 1'b1;
					end
					if (bit_end) begin
						if (last_byte) begin
							state_q <= STOP;
						end else begin
							state_q <= DATA;
							byte_q <= byte_q + 2'd1;
						end
					end
				end
				STOP: begin
					if (bit_end) begin
						state_q <= IDLE;
					end
				end
				default: state_q <= IDLE;
			endcase
		end
	end

	// Receive word, byte 0 first, MSB first.
	always_ff @(posedge clk_i2c) begin
		if (state_q == IDLE && start_i) begin
			rx_q <= '0;
		end else if (state_q == DATA && job_i.read && sample) begin
			rx_q[{byte_q, bit_q}] <= sda_i;
		end
	end

	// Lines are only ever pulled low.
	always_comb begin
		scl_oe_o = 1'b0;
		sda_oe_o = 1'b0;
		case (state_q)
			START: begin
				scl_oe_o = (phase_i.phase == 2'd3);
				sda_oe_o = phase_i.phase[1];
			end
			ADDR: begin
				scl_oe_o = scl_low;
				sda_oe_o = !addr_byte[bit_q];
			end
			ACK0: scl_oe_o = scl_low;
			DATA: begin
				scl_oe_o = scl_low;
				sda_oe_o = !job_i.read && !tx_bit;
			end
			ACK1: begin
				// Master acks all read bytes but the last.
				scl_oe_o = scl_low;
				sda_oe_o = job_i.read && !last_byte;
			end
			STOP: begin
				scl_oe_o = (phase_i.phase == 2'd0);
				sda_oe_o = !phase_i.phase[1];
			end
			default: ;
		endcase
	end

	assign status_o.busy = (state_q != IDLE);
	assign status_o.done_pulse = (state_q == STOP) && bit_end;
	assign status_o.nack = nack_q;
	assign status_o.rdata = rx_q;

endmodule

// ==== rtl/i2c_scl_gen.sv ====
`include "i2c_settings.svh"

module i2c_scl_gen
	import i2c_bus_pkg::*;
(
	input  logic       clk_i2c,
	input  logic       reset_i,
	input  logic       run_i,
	output scl_phase_t phase_o
);

	logic [7:0] div_q;
	logic [1:0] phase_q;
	logic       tick;

	// Last cycle of each quarter bit.
	assign tick = run_i && (div_q == 8'(`I2C_QUARTER_DIV - 1));

	always_ff @(posedge clk_i2c) begin
		if (reset_i || !run_i) begin
			div_q <= '0;
			phase_q <= '0;
		end else if (tick) begin
			div_q <= '0;
			phase_q <= phase_q + 2'd1;
		end else begin
			div_q <= div_q + 8'd1;
		end
	end

	assign phase_o.tick = tick;
	assign phase_o.phase = phase_q;

endmodule

// ==== rtl/i2c_regfile.sv ====
`include "i2c_settings.svh"

module i2c_regfile
	import i2c_reg_pkg::*;
	import i2c_bus_pkg::*;
(
	input  logic        clk_i2c,
	input  logic        reset_i,
	input  host_req_t   req_i,
	output logic [31:0] rdata_o,
	input  eng_status_t status_i,
	output job_t        job_o,
	output logic        start_o
);

	logic [2:0]  nby_q;
	logic [2:0]  nby_d;
	logic [6:0]  adr_q;
	logic [6:0]  adr_d;
	logic [31:0] tdr_q;
	logic [31:0] tdr_d;
	logic [31:0] rdr_q;
	cfg_word_u   cfg_q;
	cfg_word_u   cfg_wr;
	cfg_word_u   cfg_rd;
	logic        cfg_hit;
	logic        start_req;
	logic        start_q;
	logic [4:0]  lane_addr;
	logic [7:0]  rd_map [32];
	job_t        job_q;

	// Write decode, one byte lane at a time.
	always_comb begin
		nby_d = nby_q;
		adr_d = adr_q;
		tdr_d = tdr_q;
		cfg_hit = 1'b0;
		cfg_wr.raw = '0;
		lane_addr = req_i.addr;
		for (int i = 0; i < 4; i++) begin
			lane_addr = req_i.addr + 5'(i);
			if (req_i.write && req_i.be[i]) begin
				case (lane_addr)
					`I2C_OFS_NBY: nby_d = req_i.wdata[8*i +: 3];
					`I2C_OFS_ADR: adr_d = req_i.wdata[8*i +: 7];
					`I2C_OFS_TDR: tdr_d[7:0] = req_i.wdata[8*i +: 8];
					`I2C_OFS_TDR + 5'd1: tdr_d[15:8] = req_i.wdata[8*i +: 8];
					`I2C_OFS_TDR + 5'd2: tdr_d[23:16] = req_i.wdata[8*i +: 8];
					`I2C_OFS_TDR + 5'd3: tdr_d[31:24] = req_i.wdata[8*i +: 8];
					`I2C_OFS_CFG: begin
						cfg_hit = 1'b1;
						cfg_wr.raw = {24'h0, req_i.wdata[8*i +: 8]};
					end
					default: ;
				endcase
			end
		end
	end

	// A pending start counts as busy.
	assign start_req = cfg_hit && cfg_wr.f.start && !status_i.busy && !start_q;

	// Read map, unmapped bytes are zero.
	always_comb begin
		cfg_rd = cfg_q;
		cfg_rd.f.busy = status_i.busy;
		for (int a = 0; a < 32; a++) begin
			rd_map[a] = 8'h00;
		end
		rd_map[`I2C_OFS_NBY] = {5'h00, nby_q};
		rd_map[`I2C_OFS_ADR] = {1'b0, adr_q};
		for (int k = 0; k < 4; k++) begin
			rd_map[`I2C_OFS_RDR + k] = rdr_q[8*k +: 8];
			rd_map[`I2C_OFS_TDR + k] = tdr_q[8*k +: 8];
			rd_map[`I2C_OFS_CFG + k] = cfg_rd.raw[8*k +: 8];
		end
		rdata_o = '0;
		for (int i = 0; i < 4; i++) begin
			if (req_i.be[i]) begin
				rdata_o[8*i +: 8] = rd_map[5'(req_i.addr + 5'(i))];
			end
		end
	end

	always_ff @(posedge clk_i2c) begin
		if (reset_i) begin
			nby_q <= '0;
			adr_q <= '0;
			tdr_q <= '0;
			rdr_q <= '0;
			cfg_q.raw <= '0;
			start_q <= 1'b0;
		end else begin
			nby_q <= nby_d;
			adr_q <= adr_d;
			tdr_q <= tdr_d;
			start_q <= start_req;
			if (cfg_hit) begin
				cfg_q.f.read <= cfg_wr.f.read;
			end
			if (start_req) begin
				cfg_q.f.done <= 1'b0;
				cfg_q.f.nack <= 1'b0;
			end else if (status_i.done_pulse) begin
				cfg_q.f.done <= 1'b1;
				cfg_q.f.nack <= status_i.nack;
				rdr_q <= status_i.rdata;
			end
		end
	end

	// Job takes the values written in the same cycle as start.
	always_ff @(posedge clk_i2c) begin
		if (start_req) begin
			job_q <= '{target: adr_d, read: cfg_wr.f.read,
				nbytes: 2'(nby_d - 3'd1), tdata: tdr_d};
		end
	end

	assign job_o = job_q;
	assign start_o = start_q;

endmodule

// ==== rtl/i2c_bus_pkg.sv ====
package i2c_bus_pkg;

	// Quarter-bit timing from the divider.
	typedef struct packed {
		logic       tick;
		logic [1:0] phase;
	} scl_phase_t;

	// Engine state seen by the register file.
	typedef struct packed {
		logic        busy;
		logic        done_pulse;
		logic        nack;
		logic [31:0] rdata;
	} eng_status_t;

endpackage

// ==== rtl/i2c_reg_pkg.sv ====
package i2c_reg_pkg;

	// One host bus request.
	typedef struct packed {
		logic        write;
		logic [3:0]  be;
		logic [4:0]  addr;
		logic [31:0] wdata;
	} host_req_t;

	// Control register fields.
	typedef struct packed {
		logic [26:0] reserved;
		logic        done;
		logic        nack;
		logic        busy;
		logic        read;
		logic        start;
	} cfg_fields_t;

	// Control word, raw host data or decoded fields.
	typedef union packed {
		logic [31:0] raw;
		cfg_fields_t f;
	} cfg_word_u;

	// Transfer job, frozen when a start is accepted.
	typedef struct packed {
		logic [6:0]  target;
		logic        read;
		logic [1:0]  nbytes;
		logic [31:0] tdata;
	} job_t;

endpackage

// ==== rtl/i2c_settings.svh ====
`ifndef I2C_SETTINGS_SVH
`define I2C_SETTINGS_SVH

// clk_i2c cycles per quarter of an SCL bit.
`define I2C_QUARTER_DIV 4

// Host register byte offsets.
`define I2C_OFS_NBY 5'h00
`define I2C_OFS_ADR 5'h04
`define I2C_OFS_RDR 5'h08
`define I2C_OFS_TDR 5'h0C
`define I2C_OFS_CFG 5'h10

`endif
